//--- Makefile
# Verilator build and run of the store buffer testbench
TOP := tb_sbuf

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "FAIL"; \
		exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- common/sbuf_pkg.sv
// Shared store buffer types and CSR map; the entry layout is {word address, strobe, data}, top bit first
package sbuf_pkg;

    // Word address, which is the byte address without its two low bits
    typedef logic [29:0] word_addr_t;

    // Full byte address as it appears on an AXI4-Lite address channel
    typedef logic [31:0] axi_addr_t;

    // Store data and its byte lane enables
    typedef logic [31:0] word_data_t;
    typedef logic [3:0]  byte_strb_t;

    // One pending store, address in the top bits and data in the bottom bits
    typedef logic [$bits(word_addr_t)+$bits(byte_strb_t)+$bits(word_data_t)-1:0] sbuf_entry_t;

    // Byte offset of a register inside the CSR block
    typedef logic [3:0] csr_addr_t;

    // Value of one CSR as seen on the register port
    typedef logic [31:0] csr_data_t;

    // AXI response code
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Register map
    localparam csr_addr_t CSR_CTRL    = 4'h0;
    localparam csr_addr_t CSR_STATUS  = 4'h4;
    localparam csr_addr_t CSR_DRAINED = 4'h8;
    localparam csr_addr_t CSR_ERRORS  = 4'hC;

endpackage

//--- flist.f
common/sbuf_pkg.sv
store_buffer/sfifo2.sv
store_buffer/store_drain.sv
logic/sbuf_csr.sv
logic/sbuf_top.sv
test/tb_axi_mem.sv
test/tb_sbuf.sv

//--- logic/sbuf_csr.sv
// Offsets are decoded from the full 32-bit address; anything outside 0x0 to 0xC answers SLVERR
`timescale 1ns/10ps

module sbuf_csr (
    input  logic                 i_clk,
    input  logic                 i_reset,

    // AXI4-Lite write address and data
    input  logic                 i_s_awvalid,
    output logic                 o_s_awready,
    input  sbuf_pkg::axi_addr_t  i_s_awaddr,
    input  logic                 i_s_wvalid,
    output logic                 o_s_wready,
    input  sbuf_pkg::csr_data_t  i_s_wdata,
    input  sbuf_pkg::byte_strb_t i_s_wstrb,

    // AXI4-Lite write response
    output logic                 o_s_bvalid,
    input  logic                 i_s_bready,
    output sbuf_pkg::axi_resp_t  o_s_bresp,

    // AXI4-Lite read address and data
    input  logic                 i_s_arvalid,
    output logic                 o_s_arready,
    input  sbuf_pkg::axi_addr_t  i_s_araddr,
    output logic                 o_s_rvalid,
    input  logic                 i_s_rready,
    output sbuf_pkg::csr_data_t  o_s_rdata,
    output sbuf_pkg::axi_resp_t  o_s_rresp,

    // Buffer and drain engine state
    input  logic                 i_empty,
    input  logic                 i_full,
    input  logic                 i_busy,
    input  logic                 i_drained,
    input  logic                 i_err,

    output logic                 o_drain_en
);

    import sbuf_pkg::*;

    csr_data_t drained_cnt;
    csr_data_t err_cnt;
    csr_data_t rd_value;

    csr_addr_t wr_off;
    csr_addr_t rd_off;

    logic wr_take;
    logic rd_take;
    logic wr_known;
    logic rd_known;
    logic status_idle;

    // True for the four implemented register offsets
    function automatic logic offset_known(input axi_addr_t addr);
        logic hit;
        hit = 1'b0;
        if (addr[31:4] == '0) begin
            case (addr[3:0])
                CSR_CTRL, CSR_STATUS, CSR_DRAINED, CSR_ERRORS: hit = 1'b1;
                default: hit = 1'b0;
            endcase
        end
        return hit;
    endfunction

    assign wr_off   = i_s_awaddr[3:0];
    assign rd_off   = i_s_araddr[3:0];
    assign wr_known = offset_known(i_s_awaddr);
    assign rd_known = offset_known(i_s_araddr);

    // A write needs both address and data, and no response still waiting
    assign wr_take     = i_s_awvalid && i_s_wvalid && !o_s_bvalid;
    assign o_s_awready = wr_take;
    assign o_s_wready  = wr_take;

    // A read is accepted only once the previous data has been taken
    assign rd_take     = i_s_arvalid && !o_s_rvalid;
    assign o_s_arready = rd_take;

    // Nothing queued and no transaction in progress
    assign status_idle = i_empty && !i_busy;

    // Drain enable and counters, a register write takes priority over a pulse
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_drain_en  <= 1'b0;
            drained_cnt <= '0;
            err_cnt     <= '0;
        end else begin
            if (i_drained) begin
                drained_cnt <= drained_cnt + 1'b1;
            end
            if (i_err) begin
                err_cnt <= err_cnt + 1'b1;
            end
            if (wr_take && wr_known) begin
                case (wr_off)
                    CSR_CTRL: begin
                        if (i_s_wstrb[0]) begin
                            o_drain_en <= i_s_wdata[0];
                        end
                    end
                    // Any write to a counter clears it, whatever the data
                    CSR_DRAINED: drained_cnt <= '0;
                    CSR_ERRORS:  err_cnt <= '0;
                    default: ;
                endcase
            end
        end
    end

    // Write response handshake
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_s_bvalid <= 1'b0;
        end else if (wr_take) begin
            o_s_bvalid <= 1'b1;
        end else if (i_s_bready) begin
            o_s_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_take) begin
            o_s_bresp <= wr_known ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Read data mux, unknown offsets read as zero
    always_comb begin
        rd_value = '0;
        case (rd_off)
            CSR_CTRL:    rd_value[0] = o_drain_en;
            CSR_STATUS:  rd_value[2:0] = {status_idle, i_full, i_empty};
            CSR_DRAINED: rd_value = drained_cnt;
            CSR_ERRORS:  rd_value = err_cnt;
            default:     rd_value = '0;
        endcase
        if (!rd_known) begin
            rd_value = '0;
        end
    end

    // Read data handshake
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_s_rvalid <= 1'b0;
        end else if (rd_take) begin
            o_s_rvalid <= 1'b1;
        end else if (i_s_rready) begin
            o_s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_take) begin
            o_s_rdata <= rd_value;
            o_s_rresp <= rd_known ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

//--- logic/sbuf_top.sv
// SBUF_DEPTH must be a power of two of at least 2; only the AXI write channels exist on the memory side
`timescale 1ns/10ps

module sbuf_top #(
    parameter int SBUF_DEPTH = 8
) (
    input  logic                 i_clk,
    input  logic                 i_reset,

    // Core store port
    input  logic                 i_st_valid,
    output logic                 o_st_ready,
    input  sbuf_pkg::word_addr_t i_st_addr,
    input  sbuf_pkg::byte_strb_t i_st_strb,
    input  sbuf_pkg::word_data_t i_st_data,

    // AXI4-Lite master, write channels
    output logic                 o_m_awvalid,
    input  logic                 i_m_awready,
    output sbuf_pkg::axi_addr_t  o_m_awaddr,
    output logic                 o_m_wvalid,
    input  logic                 i_m_wready,
    output sbuf_pkg::word_data_t o_m_wdata,
    output sbuf_pkg::byte_strb_t o_m_wstrb,
    input  logic                 i_m_bvalid,
    output logic                 o_m_bready,
    input  sbuf_pkg::axi_resp_t  i_m_bresp,

    // AXI4-Lite slave for the registers
    input  logic                 i_s_awvalid,
    output logic                 o_s_awready,
    input  sbuf_pkg::axi_addr_t  i_s_awaddr,
    input  logic                 i_s_wvalid,
    output logic                 o_s_wready,
    input  sbuf_pkg::csr_data_t  i_s_wdata,
    input  sbuf_pkg::byte_strb_t i_s_wstrb,
    output logic                 o_s_bvalid,
    input  logic                 i_s_bready,
    output sbuf_pkg::axi_resp_t  o_s_bresp,
    input  logic                 i_s_arvalid,
    output logic                 o_s_arready,
    input  sbuf_pkg::axi_addr_t  i_s_araddr,
    output logic                 o_s_rvalid,
    input  logic                 i_s_rready,
    output sbuf_pkg::csr_data_t  o_s_rdata,
    output sbuf_pkg::axi_resp_t  o_s_rresp,

    // High when every accepted store has reached memory, usable for fences
    output logic                 o_sb_idle
);

    import sbuf_pkg::*;

    sbuf_entry_t st_entry;
    sbuf_entry_t head_entry;

    logic fifo_full;
    logic fifo_empty;
    logic pop;
    logic drain_en;
    logic drained_pulse;
    logic err_pulse;
    logic busy;

    // Pack the store fields in the order the drain engine expects
    assign st_entry   = {i_st_addr, i_st_strb, i_st_data};
    assign o_st_ready = !fifo_full;
    assign o_sb_idle  = fifo_empty && !busy;

    sfifo2 #(
        .FW (SBUF_DEPTH),
        .DW ($bits(sbuf_entry_t))
    ) u_fifo (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr_en   (i_st_valid && o_st_ready),
        .i_wr_data (st_entry),
        .o_full    (fifo_full),
        .i_rd      (pop),
        .o_rd_data (head_entry),
        .o_empty   (fifo_empty)
    );

    store_drain u_drain (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_drain_en  (drain_en),
        .i_empty     (fifo_empty),
        .i_entry     (head_entry),
        .o_pop       (pop),
        .o_m_awvalid (o_m_awvalid),
        .i_m_awready (i_m_awready),
        .o_m_awaddr  (o_m_awaddr),
        .o_m_wvalid  (o_m_wvalid),
        .i_m_wready  (i_m_wready),
        .o_m_wdata   (o_m_wdata),
        .o_m_wstrb   (o_m_wstrb),
        .i_m_bvalid  (i_m_bvalid),
        .o_m_bready  (o_m_bready),
        .i_m_bresp   (i_m_bresp),
        .o_drained   (drained_pulse),
        .o_err       (err_pulse),
        .o_busy      (busy)
    );

    sbuf_csr u_csr (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_s_awvalid (i_s_awvalid),
        .o_s_awready (o_s_awready),
        .i_s_awaddr  (i_s_awaddr),
        .i_s_wvalid  (i_s_wvalid),
        .o_s_wready  (o_s_wready),
        .i_s_wdata   (i_s_wdata),
        .i_s_wstrb   (i_s_wstrb),
        .o_s_bvalid  (o_s_bvalid),
        .i_s_bready  (i_s_bready),
        .o_s_bresp   (o_s_bresp),
        .i_s_arvalid (i_s_arvalid),
        .o_s_arready (o_s_arready),
        .i_s_araddr  (i_s_araddr),
        .o_s_rvalid  (o_s_rvalid),
        .i_s_rready  (i_s_rready),
        .o_s_rdata   (o_s_rdata),
        .o_s_rresp   (o_s_rresp),
        .i_empty     (fifo_empty),
        .i_full      (fifo_full),
        .i_busy      (busy),
        .i_drained   (drained_pulse),
        .i_err       (err_pulse),
        .o_drain_en  (drain_en)
    );

endmodule

//--- store_buffer/sfifo2.sv
// FW must be a power of two of at least 2; a write while full and a read while empty are dropped
`timescale 1ns/10ps

module sfifo2 #(
    parameter int FW = 8,
    parameter int DW = 66
) (
    input  logic          i_clk,
    input  logic          i_reset,
    input  logic          i_wr_en,
    input  logic [DW-1:0] i_wr_data,
    output logic          o_full,
    input  logic          i_rd,
    output logic [DW-1:0] o_rd_data,
    output logic          o_empty
);

    localparam int AW = $clog2(FW);

    // Storage has no reset, only the pointers carry state that matters
    logic [DW-1:0] mem [FW];

    // Both pointers have one bit above the index, which flips on every wrap
    logic [AW:0] head_ptr;
    logic [AW:0] tail_ptr;

    logic do_write;
    logic do_read;

    assign do_write = i_wr_en && !o_full;
    assign do_read  = i_rd && !o_empty;

    // Same index and same wrap bit means nothing is stored
    assign o_empty = (head_ptr == tail_ptr);

    // Same index with differing wrap bits means the tail has lapped the head
    assign o_full = (head_ptr[AW] != tail_ptr[AW]) &&
                    (head_ptr[AW-1:0] == tail_ptr[AW-1:0]);

    // The head entry is presented combinationally
    assign o_rd_data = mem[head_ptr[AW-1:0]];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (do_write) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (do_read) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_write) begin
            mem[tail_ptr[AW-1:0]] <= i_wr_data;
        end
    end

endmodule

//--- store_buffer/store_drain.sv
// One AXI4-Lite write in flight at a time; the head entry is popped only after its B response
`timescale 1ns/10ps

module store_drain (
    input  logic                  i_clk,
    input  logic                  i_reset,

    // Control from the register block
    input  logic                  i_drain_en,

    // Head of the store buffer
    input  logic                  i_empty,
    input  sbuf_pkg::sbuf_entry_t i_entry,
    output logic                  o_pop,

    // AXI4-Lite write address channel
    output logic                  o_m_awvalid,
    input  logic                  i_m_awready,
    output sbuf_pkg::axi_addr_t   o_m_awaddr,

    // AXI4-Lite write data channel
    output logic                  o_m_wvalid,
    input  logic                  i_m_wready,
    output sbuf_pkg::word_data_t  o_m_wdata,
    output sbuf_pkg::byte_strb_t  o_m_wstrb,

    // AXI4-Lite write response channel
    input  logic                  i_m_bvalid,
    output logic                  o_m_bready,
    input  sbuf_pkg::axi_resp_t   i_m_bresp,

    // Completion reporting
    output logic                  o_drained,
    output logic                  o_err,
    output logic                  o_busy
);

    import sbuf_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_B
    } drain_state_t;

    drain_state_t state;

    word_addr_t head_addr;
    byte_strb_t head_strb;
    word_data_t head_data;

    logic start;
    logic aw_done;
    logic w_done;
    logic b_done;
    logic aw_clear;
    logic w_clear;

    // Split the head entry into its fields
    assign {head_addr, head_strb, head_data} = i_entry;

    // A new write only begins from IDLE, and only while the drain is enabled
    assign start = (state == IDLE) && i_drain_en && !i_empty;

    assign aw_done = o_m_awvalid && i_m_awready;
    assign w_done  = o_m_wvalid && i_m_wready;
    assign b_done  = o_m_bready && i_m_bvalid;

    // A channel counts as finished once its handshake happens now or has happened before
    assign aw_clear = aw_done || !o_m_awvalid;
    assign w_clear  = w_done || !o_m_wvalid;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= IDLE;
            o_m_awvalid <= 1'b0;
            o_m_wvalid  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state       <= SEND;
                        o_m_awvalid <= 1'b1;
                        o_m_wvalid  <= 1'b1;
                    end
                end
                SEND: begin
                    // AW and W may be taken in either order or on the same edge
                    if (aw_done) begin
                        o_m_awvalid <= 1'b0;
                    end
                    if (w_done) begin
                        o_m_wvalid <= 1'b0;
                    end
                    if (aw_clear && w_clear) begin
                        state <= WAIT_B;
                    end
                end
                WAIT_B: begin
                    if (b_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Capture the head entry for the whole transaction
    always_ff @(posedge i_clk) begin
        if (start) begin
            o_m_awaddr <= {head_addr, 2'b00};
            o_m_wdata  <= head_data;
            o_m_wstrb  <= head_strb;
        end
    end

    assign o_m_bready = (state == WAIT_B);

    // The store leaves the buffer on the same edge memory acknowledges it
    assign o_pop     = b_done;
    assign o_drained = b_done;
    assign o_err     = b_done && (i_m_bresp != RESP_OKAY);
    assign o_busy    = (state != IDLE);

endmodule

//--- test/tb_axi_mem.sv
// Write-only AXI4-Lite memory, one write at a time; SLVERR when byte address bit 31 is set
`timescale 1ns/10ps

module tb_axi_mem (
    input  logic                 i_clk,
    input  logic                 i_reset,

    // Random bits from the testbench, a fresh word every cycle
    input  logic [31:0]          i_rnd,

    // AXI4-Lite write channels, slave side
    input  logic                 i_awvalid,
    output logic                 o_awready,
    input  sbuf_pkg::axi_addr_t  i_awaddr,
    input  logic                 i_wvalid,
    output logic                 o_wready,
    input  sbuf_pkg::word_data_t i_wdata,
    input  sbuf_pkg::byte_strb_t i_wstrb,
    output logic                 o_bvalid,
    input  logic                 i_bready,
    output sbuf_pkg::axi_resp_t  o_bresp,

    // Copy of each accepted write, valid while o_wr_fire is high
    output logic                 o_wr_fire,
    output sbuf_pkg::axi_addr_t  o_wr_addr,
    output sbuf_pkg::byte_strb_t o_wr_strb,
    output sbuf_pkg::word_data_t o_wr_data
);

    import sbuf_pkg::*;

    logic       have_aw;
    logic       have_w;
    logic       armed;
    logic [2:0] delay;
    logic       aw_take;
    logic       w_take;

    assign aw_take = i_awvalid && o_awready;
    assign w_take  = i_wvalid && o_wready;

    // The master sees known values before the first clock edge
    initial begin
        o_awready <= 1'b0;
        o_wready  <= 1'b0;
        o_bvalid  <= 1'b0;
        o_bresp   <= RESP_OKAY;
        o_wr_fire <= 1'b0;
    end

    always @(posedge i_clk) begin
        if (i_reset) begin
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_bvalid  <= 1'b0;
            o_bresp   <= RESP_OKAY;
            o_wr_fire <= 1'b0;
            have_aw   <= 1'b0;
            have_w    <= 1'b0;
            armed     <= 1'b0;
            delay     <= '0;
        end else begin
            o_wr_fire <= 1'b0;
            // Ready flickers at random but never while a beat is already held
            o_awready <= !have_aw && !aw_take && i_rnd[0];
            o_wready  <= !have_w && !w_take && i_rnd[1];
            if (aw_take) begin
                have_aw   <= 1'b1;
                o_wr_addr <= i_awaddr;
            end
            if (w_take) begin
                have_w    <= 1'b1;
                o_wr_data <= i_wdata;
                o_wr_strb <= i_wstrb;
            end
            // Both halves captured, so report the write and pick a response delay
            if (have_aw && have_w && !armed && !o_bvalid) begin
                armed     <= 1'b1;
                delay     <= i_rnd[5:3];
                o_wr_fire <= 1'b1;
            end
            if (armed) begin
                if (delay == 3'd0) begin
                    armed    <= 1'b0;
                    o_bvalid <= 1'b1;
                    // Word address bit 29 lands on byte address bit 31
                    o_bresp  <= o_wr_addr[31] ? RESP_SLVERR : RESP_OKAY;
                end else begin
                    delay <= delay - 3'd1;
                end
            end
            if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
                have_aw  <= 1'b0;
                have_w   <= 1'b0;
            end
        end
    end

endmodule

//--- test/tb_sbuf.sv
// Self-checking testbench for sbuf_top at depth 8; stimulus and memory timing are fixed by seed 25
`timescale 1ns/10ps

module tb_sbuf;

    import sbuf_pkg::*;

    localparam int SBUF_DEPTH     = 8;
    localparam int N_STORES       = 200;
    // Generous budget of 200 cycles for every store the run can send
    localparam int TIMEOUT_CYCLES = 200 * (N_STORES + 2 * SBUF_DEPTH);

    logic clk = 1'b0;
    logic reset;

    // Store port
    logic       st_valid;
    logic       st_ready;
    word_addr_t st_addr;
    byte_strb_t st_strb;
    word_data_t st_data;

    // Memory side
    logic       m_awvalid;
    logic       m_awready;
    axi_addr_t  m_awaddr;
    logic       m_wvalid;
    logic       m_wready;
    word_data_t m_wdata;
    byte_strb_t m_wstrb;
    logic       m_bvalid;
    logic       m_bready;
    axi_resp_t  m_bresp;

    // Register port
    logic       s_awvalid;
    logic       s_awready;
    axi_addr_t  s_awaddr;
    logic       s_wvalid;
    logic       s_wready;
    csr_data_t  s_wdata;
    byte_strb_t s_wstrb;
    logic       s_bvalid;
    logic       s_bready;
    axi_resp_t  s_bresp;
    logic       s_arvalid;
    logic       s_arready;
    axi_addr_t  s_araddr;
    logic       s_rvalid;
    logic       s_rready;
    csr_data_t  s_rdata;
    axi_resp_t  s_rresp;
    logic       sb_idle;

    // Writes seen by the memory model
    logic       wr_fire;
    axi_addr_t  wr_addr;
    byte_strb_t wr_strb;
    word_data_t wr_data;
    logic [31:0] mem_rnd;

    // Reference model, stores in acceptance order and the responses they should get
    sbuf_entry_t exp_q[$];
    int          sent = 0;
    int          exp_errors = 0;
    int          wr_count = 0;
    logic [31:0] rng;

    always #5 clk = ~clk;

    sbuf_top #(
        .SBUF_DEPTH (SBUF_DEPTH)
    ) uut (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_st_valid  (st_valid),
        .o_st_ready  (st_ready),
        .i_st_addr   (st_addr),
        .i_st_strb   (st_strb),
        .i_st_data   (st_data),
        .o_m_awvalid (m_awvalid),
        .i_m_awready (m_awready),
        .o_m_awaddr  (m_awaddr),
        .o_m_wvalid  (m_wvalid),
        .i_m_wready  (m_wready),
        .o_m_wdata   (m_wdata),
        .o_m_wstrb   (m_wstrb),
        .i_m_bvalid  (m_bvalid),
        .o_m_bready  (m_bready),
        .i_m_bresp   (m_bresp),
        .i_s_awvalid (s_awvalid),
        .o_s_awready (s_awready),
        .i_s_awaddr  (s_awaddr),
        .i_s_wvalid  (s_wvalid),
        .o_s_wready  (s_wready),
        .i_s_wdata   (s_wdata),
        .i_s_wstrb   (s_wstrb),
        .o_s_bvalid  (s_bvalid),
        .i_s_bready  (s_bready),
        .o_s_bresp   (s_bresp),
        .i_s_arvalid (s_arvalid),
        .o_s_arready (s_arready),
        .i_s_araddr  (s_araddr),
        .o_s_rvalid  (s_rvalid),
        .i_s_rready  (s_rready),
        .o_s_rdata   (s_rdata),
        .o_s_rresp   (s_rresp),
        .o_sb_idle   (sb_idle)
    );

    tb_axi_mem u_mem (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_rnd     (mem_rnd),
        .i_awvalid (m_awvalid),
        .o_awready (m_awready),
        .i_awaddr  (m_awaddr),
        .i_wvalid  (m_wvalid),
        .o_wready  (m_wready),
        .i_wdata   (m_wdata),
        .i_wstrb   (m_wstrb),
        .o_bvalid  (m_bvalid),
        .i_bready  (m_bready),
        .o_bresp   (m_bresp),
        .o_wr_fire (wr_fire),
        .o_wr_addr (wr_addr),
        .o_wr_strb (wr_strb),
        .o_wr_data (wr_data)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Memory timing draws from its own stream, stepped once per cycle
    always @(posedge clk) begin
        if (reset) begin
            mem_rnd <= 32'd25;
        end else begin
            mem_rnd <= xorshift32(mem_rnd);
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Offer one store and hold it until the buffer takes it
    task automatic send_store(input word_addr_t a, input byte_strb_t s, input word_data_t d);
        @(posedge clk);
        st_valid <= 1'b1;
        st_addr  <= a;
        st_strb  <= s;
        st_data  <= d;
        @(negedge clk);
        while (!st_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        st_valid <= 1'b0;
        exp_q.push_back({a, s, d});
        sent = sent + 1;
        if (a[29]) begin
            exp_errors = exp_errors + 1;
        end
    endtask

    task automatic random_store();
        word_addr_t a;
        byte_strb_t s;
        word_data_t d;
        rng = xorshift32(rng);
        a = rng[29:0];
        rng = xorshift32(rng);
        d = rng;
        rng = xorshift32(rng);
        s = rng[3:0];
        send_store(a, s, d);
    endtask

    task automatic csr_write(input axi_addr_t addr, input csr_data_t data, output axi_resp_t resp);
        @(posedge clk);
        s_awvalid <= 1'b1;
        s_awaddr  <= addr;
        s_wvalid  <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= 4'hF;
        @(negedge clk);
        while (!s_awready) begin
            @(negedge clk);
        end
        // Address and data are taken together on the same edge
        check("s_wready", 64'(s_wready), 64'd1);
        @(posedge clk);
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        s_bready  <= 1'b1;
        @(negedge clk);
        while (!s_bvalid) begin
            @(negedge clk);
        end
        resp = s_bresp;
        @(posedge clk);
        s_bready <= 1'b0;
    endtask

    task automatic csr_read(input axi_addr_t addr, output csr_data_t data, output axi_resp_t resp);
        @(posedge clk);
        s_arvalid <= 1'b1;
        s_araddr  <= addr;
        @(negedge clk);
        while (!s_arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        s_arvalid <= 1'b0;
        s_rready  <= 1'b1;
        @(negedge clk);
        while (!s_rvalid) begin
            @(negedge clk);
        end
        data = s_rdata;
        resp = s_rresp;
        @(posedge clk);
        s_rready <= 1'b0;
    endtask

    task automatic read_expect(input axi_addr_t addr, input csr_data_t exp);
        csr_data_t data;
        axi_resp_t resp;
        csr_read(addr, data, resp);
        check($sformatf("s_rdata at 0x%h", addr), 64'(data), 64'(exp));
        check("s_rresp", 64'(resp), 64'(RESP_OKAY));
    endtask

    task automatic write_expect(input axi_addr_t addr, input csr_data_t data, input axi_resp_t exp);
        axi_resp_t resp;
        csr_write(addr, data, resp);
        check($sformatf("s_bresp at 0x%h", addr), 64'(resp), 64'(exp));
    endtask

    // Hold until the model queue is empty and the last B response is back
    task automatic wait_drained();
        while (exp_q.size() != 0 || !sb_idle) begin
            @(negedge clk);
        end
    endtask

    // Every write reaching memory must be the oldest store not yet written
    always @(negedge clk) begin
        sbuf_entry_t head;
        if (!reset && wr_fire) begin
            if (exp_q.size() == 0) begin
                fail_run("error: memory received a write while no store was pending");
            end else begin
                head = exp_q.pop_front();
                check("m_awaddr", 64'(wr_addr), 64'({head[65:36], 2'b00}));
                check("m_wstrb", 64'(wr_strb), 64'(head[35:32]));
                check("m_wdata", 64'(wr_data), 64'(head[31:0]));
                wr_count = wr_count + 1;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run("error: timeout, the testbench did not finish within its cycle budget");
    end

    initial begin
        csr_data_t rdata;
        axi_resp_t resp;
        int        accepted;
        int        base;
        rng = 32'd25;
        reset     <= 1'b1;
        st_valid  <= 1'b0;
        st_addr   <= '0;
        st_strb   <= '0;
        st_data   <= '0;
        s_awvalid <= 1'b0;
        s_awaddr  <= '0;
        s_wvalid  <= 1'b0;
        s_wdata   <= '0;
        s_wstrb   <= '0;
        s_bready  <= 1'b0;
        s_arvalid <= 1'b0;
        s_araddr  <= '0;
        s_rready  <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Outputs come out of reset quiet, with the store port open
        check("m_awvalid", 64'(m_awvalid), 64'd0);
        check("m_wvalid", 64'(m_wvalid), 64'd0);
        check("m_bready", 64'(m_bready), 64'd0);
        check("s_bvalid", 64'(s_bvalid), 64'd0);
        check("s_rvalid", 64'(s_rvalid), 64'd0);
        check("st_ready", 64'(st_ready), 64'd1);

        // Register block basics, status is empty plus idle
        read_expect(32'(CSR_CTRL), 32'h0);
        read_expect(32'(CSR_STATUS), 32'h5);
        write_expect(32'(CSR_CTRL), 32'h1, RESP_OKAY);
        read_expect(32'(CSR_CTRL), 32'h1);
        write_expect(32'(CSR_CTRL), 32'h0, RESP_OKAY);
        read_expect(32'(CSR_CTRL), 32'h0);
        csr_read(32'h10, rdata, resp);
        check("s_rdata at 0x10", 64'(rdata), 64'd0);
        check("s_rresp at 0x10", 64'(resp), 64'(RESP_SLVERR));
        write_expect(32'h10, 32'hFFFF_FFFF, RESP_SLVERR);

        // Drain off, so the buffer must close after exactly SBUF_DEPTH stores
        accepted = 0;
        @(negedge clk);
        while (st_ready && accepted < 2 * SBUF_DEPTH) begin
            random_store();
            accepted = accepted + 1;
            @(negedge clk);
        end
        check("accepted stores", 64'(accepted), 64'(SBUF_DEPTH));
        read_expect(32'(CSR_STATUS), 32'h2);
        check("memory writes", 64'(wr_count), 64'd0);

        // In-order drain of the backlog plus a long random stream
        write_expect(32'(CSR_CTRL), 32'h1, RESP_OKAY);
        for (int n = 0; n < N_STORES; n++) begin
            rng = xorshift32(rng);
            repeat (int'(rng[1:0])) @(posedge clk);
            random_store();
        end
        wait_drained();
        read_expect(32'(CSR_DRAINED), 32'(sent));
        read_expect(32'(CSR_ERRORS), 32'(exp_errors));

        // Counters clear on any write
        write_expect(32'(CSR_DRAINED), 32'h1234_5678, RESP_OKAY);
        write_expect(32'(CSR_ERRORS), 32'h0, RESP_OKAY);
        read_expect(32'(CSR_DRAINED), 32'h0);
        read_expect(32'(CSR_ERRORS), 32'h0);
        read_expect(32'(CSR_STATUS), 32'h5);
        @(negedge clk);
        check("sb_idle", 64'(sb_idle), 64'd1);
        sent = 0;
        exp_errors = 0;

        // Switch the drain off with traffic in flight, one started write may finish
        repeat (4) random_store();
        write_expect(32'(CSR_CTRL), 32'h0, RESP_OKAY);
        base = wr_count;
        repeat (4) random_store();
        repeat (100) @(negedge clk);
        check("writes after drain off", 64'((wr_count - base) <= 1), 64'd1);
        base = wr_count;
        repeat (50) @(negedge clk);
        check("memory writes while stopped", 64'(wr_count), 64'(base));
        csr_read(32'(CSR_STATUS), rdata, resp);
        check("status empty bit", 64'(rdata[0]), 64'd0);
        check("status idle bit", 64'(rdata[2]), 64'd0);

        // Back on, the rest must leave in order
        write_expect(32'(CSR_CTRL), 32'h1, RESP_OKAY);
        wait_drained();
        read_expect(32'(CSR_DRAINED), 32'(sent));
        read_expect(32'(CSR_ERRORS), 32'(exp_errors));
        read_expect(32'(CSR_STATUS), 32'h5);

        $display("No errors");
        $finish;
    end

endmodule
